// File: compile.f
rtl/spi_pkg.sv
rtl/display_pkg.sv
rtl/spi_cmd_if.sv
rtl/spi_peripheral.sv
rtl/chip_csr.sv
rtl/palette_ram.sv
rtl/response_combiner.sv
rtl/frame_ctrl_top.sv
verif/frame_ctrl_chk.sv
verif/tb_frame_ctrl.sv

// File: rtl/chip_csr.sv
//##########################################################################
// Chip ID and PLL control/status registers
//##########################################################################
`timescale 1ns/1ps

module chip_csr (
    input  logic           clock,
    input  logic           rst_n,
    spi_cmd_if.csr_sink    cmd,
    input  logic           pll_locked,
    output logic           pll_power_up,
    output logic           buffer_read_select,
    output spi_pkg::byte_t response,
    output logic           hit
);
    import spi_pkg::*;

    logic [SYNC_STAGES-1:0] lock_sync;
    logic                   lock_now;
    logic                   ctrl_write;
    logic                   select_hold;
    byte_t                  status;

    assign cmd.csr_ready = 1'b1;          // Never stalls
    assign lock_now      = lock_sync[SYNC_STAGES-1];
    assign ctrl_write    = cmd.operand_valid && cmd.operand_ready &&
                           (cmd.opcode == OP_PLL_CTRL) && (cmd.operand_count == '0);
    // Clock switch needs a settled source, so no select change while PLL is up but unlocked
    assign select_hold   = pll_power_up & ~lock_now;

    always_comb begin
        status               = '0;
        status[PLL_PWR_BIT]  = pll_power_up;
        status[PLL_SEL_BIT]  = buffer_read_select;
        status[PLL_LOCK_BIT] = lock_now;
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            lock_sync          <= '0;
            pll_power_up       <= 1'b1;       // PLL runs out of reset
            buffer_read_select <= 1'b0;
            hit                <= 1'b0;
        end else begin
            lock_sync <= {lock_sync[SYNC_STAGES-2:0], pll_locked};
            if (ctrl_write) begin
                pll_power_up <= cmd.operand[PLL_PWR_BIT];
                if (!select_hold) buffer_read_select <= cmd.operand[PLL_SEL_BIT];
            end
            if (cmd.read_strobe) begin
                hit <= (cmd.opcode == OP_CHIP_ID) || (cmd.opcode == OP_PLL_CTRL);
            end
        end
    end

    // Same byte for every response slot of the frame
    always_ff @(posedge clock) begin
        if (cmd.read_strobe) begin
            case (cmd.opcode)
                OP_CHIP_ID:  response <= CHIP_ID_VALUE;
                OP_PLL_CTRL: response <= status;
                default:     response <= '0;
            endcase
        end
    end

endmodule

// File: rtl/display_pkg.sv
//##########################################################################
// Display palette geometry and YCbCr entry layout
//##########################################################################

package display_pkg;

    localparam int PAL_DEPTH   = 16;
    localparam int PAL_INDEX_W = $clog2(PAL_DEPTH);   // Upper index bits dropped

    // Colour fields, all packed into the low end of their SPI bytes
    localparam int Y_W  = 4;
    localparam int CB_W = 3;      // CbCr byte bits 2:0
    localparam int CR_W = 3;      // CbCr byte bits 5:3

    // One palette entry, written whole
    typedef struct packed {
        logic [CR_W-1:0] cr;
        logic [CB_W-1:0] cb;
        logic [Y_W-1:0]  y;
    } palette_entry_t;

endpackage

// File: rtl/frame_ctrl_top.sv
//##########################################################################
// Register-access top: SPI peripheral, CSR and palette blocks, response merge
//##########################################################################
`timescale 1ns/1ps

module frame_ctrl_top (
    input  logic clock,
    input  logic rst_n,
    input  logic spi_sclk,
    input  logic spi_cs_n,
    input  logic spi_mosi,
    input  logic pll_locked,
    output logic spi_miso,
    output logic pll_power_up,
    output logic buffer_read_select,
    output logic decode_error
);
    import spi_pkg::*;

    byte_t csr_response;
    byte_t pal_response;
    byte_t response;
    logic  csr_hit;
    logic  pal_hit;

    spi_cmd_if cmd ();

    // Operand moves only when both blocks can take it
    assign cmd.operand_ready = cmd.csr_ready & cmd.pal_ready;

    spi_peripheral u_spi_peripheral (
        .clock    (clock),
        .rst_n    (rst_n),
        .spi_sclk (spi_sclk),
        .spi_cs_n (spi_cs_n),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso),
        .cmd      (cmd.source),
        .response (response)
    );

    chip_csr u_chip_csr (
        .clock              (clock),
        .rst_n              (rst_n),
        .cmd                (cmd.csr_sink),
        .pll_locked         (pll_locked),         // Async pin, synchronised inside
        .pll_power_up       (pll_power_up),
        .buffer_read_select (buffer_read_select),
        .response           (csr_response),
        .hit                (csr_hit)
    );

    palette_ram u_palette_ram (
        .clock    (clock),
        .rst_n    (rst_n),
        .cmd      (cmd.pal_sink),
        .response (pal_response),
        .hit      (pal_hit)
    );

    response_combiner u_response_combiner (
        .clock        (clock),
        .rst_n        (rst_n),
        .read_strobe  (cmd.read_strobe),
        .csr_response (csr_response),
        .csr_hit      (csr_hit),
        .pal_response (pal_response),
        .pal_hit      (pal_hit),
        .response     (response),
        .decode_error (decode_error)
    );

endmodule

// File: rtl/palette_ram.sv
//##########################################################################
// 16-entry YCbCr display palette, whole-entry writes and indexed read-back
//##########################################################################
`timescale 1ns/1ps

module palette_ram (
    input  logic           clock,
    input  logic           rst_n,
    spi_cmd_if.pal_sink    cmd,
    output spi_pkg::byte_t response,
    output logic           hit
);
    import spi_pkg::*;
    import display_pkg::*;

    palette_entry_t         pal_mem [PAL_DEPTH];
    logic [PAL_DEPTH-1:0]   entry_valid;      // Unwritten entries read as zero
    logic [PAL_INDEX_W-1:0] wr_index;
    logic [PAL_INDEX_W-1:0] rd_ptr;
    palette_entry_t         wr_entry;         // Staged until the CbCr operand
    palette_entry_t         rd_entry;
    logic                   wr_pending;
    logic                   accept;
    logic                   own_op;

    assign accept        = cmd.operand_valid & cmd.operand_ready;
    assign cmd.pal_ready = ~wr_pending;       // One-cycle stall for the commit
    assign own_op        = cmd.opcode inside {OP_PAL_WRITE, OP_PAL_INDEX, OP_PAL_READ};
    assign rd_entry      = entry_valid[rd_ptr] ? pal_mem[rd_ptr] : '0;

    // Operand staging
    always_ff @(posedge clock) begin
        if (accept && (cmd.opcode == OP_PAL_WRITE)) begin
            case (cmd.operand_count)
                0: wr_index <= cmd.operand[PAL_INDEX_W-1:0];   // Wraps above 15
                1: wr_entry.y <= cmd.operand[Y_W-1:0];
                2: begin
                    wr_entry.cb <= cmd.operand[CB_W-1:0];
                    wr_entry.cr <= cmd.operand[CB_W +: CR_W];
                end
                default: ;                                     // Extra bytes dropped
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (wr_pending) pal_mem[wr_index] <= wr_entry;
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr_pending  <= 1'b0;
            entry_valid <= '0;
            rd_ptr      <= '0;
            hit         <= 1'b0;
        end else begin
            // Commit only once the third operand is in
            wr_pending <= accept && (cmd.opcode == OP_PAL_WRITE) && (cmd.operand_count == 2);
            if (wr_pending) entry_valid[wr_index] <= 1'b1;
            if (accept && (cmd.opcode == OP_PAL_INDEX) && (cmd.operand_count == '0)) begin
                rd_ptr <= cmd.operand[PAL_INDEX_W-1:0];
            end
            if (cmd.read_strobe) hit <= own_op;   // Write opcodes claim too
        end
    end

    // Y first, CbCr for every later byte
    always_ff @(posedge clock) begin
        if (cmd.read_strobe) begin
            if (cmd.opcode != OP_PAL_READ) begin
                response <= '0;
            end else if (cmd.read_count == '0) begin
                response <= {{(BYTE_W - Y_W){1'b0}}, rd_entry.y};
            end else begin
                response <= {{(BYTE_W - CB_W - CR_W){1'b0}}, rd_entry.cr, rd_entry.cb};
            end
        end
    end

endmodule

// File: rtl/response_combiner.sv
//##########################################################################
// Response merge with sticky flag for unclaimed or doubly claimed opcodes
//##########################################################################
`timescale 1ns/1ps

module response_combiner (
    input  logic           clock,
    input  logic           rst_n,
    input  logic           read_strobe,
    input  spi_pkg::byte_t csr_response,
    input  logic           csr_hit,
    input  spi_pkg::byte_t pal_response,
    input  logic           pal_hit,
    output spi_pkg::byte_t response,
    output logic           decode_error
);
    import spi_pkg::*;

    logic  strobe_d;      // Block responses valid this cycle
    byte_t claimed;

    always_comb begin
        case ({csr_hit, pal_hit})
            2'b10:   claimed = csr_response;
            2'b01:   claimed = pal_response;
            default: claimed = '0;            // Nobody, or a clash
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            strobe_d     <= 1'b0;
            response     <= '0;
            decode_error <= 1'b0;
        end else begin
            strobe_d <= read_strobe;
            if (strobe_d) begin
                response <= claimed;
                if (csr_hit == pal_hit) decode_error <= 1'b1;   // Held until reset
            end
        end
    end

endmodule

// File: rtl/spi_cmd_if.sv
//##########################################################################
// Command bus from the SPI peripheral to the register blocks
//##########################################################################
`timescale 1ns/1ps

interface spi_cmd_if;
    import spi_pkg::*;

    byte_t  opcode;
    byte_t  operand;
    count_t operand_count;    // Index within the transaction
    logic   operand_valid;
    logic   operand_ready;    // AND of the block readies
    logic   csr_ready;
    logic   pal_ready;
    logic   read_strobe;      // Next response byte wanted
    count_t read_count;
    logic   frame_active;     // CS low and opcode received

    modport source (output opcode, operand, operand_count, operand_valid,
                    read_strobe, read_count, frame_active, input operand_ready);

    modport csr_sink (input opcode, operand, operand_count, operand_valid, operand_ready,
                      read_strobe, read_count, frame_active, output csr_ready);

    modport pal_sink (input opcode, operand, operand_count, operand_valid, operand_ready,
                      read_strobe, read_count, frame_active, output pal_ready);

endinterface

// File: rtl/spi_peripheral.sv
//##########################################################################
// Oversampled mode-0 SPI slave framing opcode, operands and read responses
//##########################################################################
`timescale 1ns/1ps

module spi_peripheral (
    input  logic           clock,
    input  logic           rst_n,
    input  logic           spi_sclk,
    input  logic           spi_cs_n,
    input  logic           spi_mosi,
    output logic           spi_miso,
    spi_cmd_if.source      cmd,
    input  spi_pkg::byte_t response
);
    import spi_pkg::*;

    logic [SYNC_STAGES-1:0] sclk_sync;
    logic [SYNC_STAGES-1:0] cs_sync;
    logic [SYNC_STAGES-1:0] mosi_sync;
    logic                   sclk_prev;
    logic                   cs_prev;
    logic                   sclk_rise;
    logic                   sclk_fall;
    logic                   cs_low;
    logic                   cs_fall;
    logic [BIT_CNT_W-1:0]   bit_count;    // Rising edges in current byte
    logic                   byte_done;
    byte_t                  shift_in;
    byte_t                  shift_out;
    byte_t                  rx_byte;
    count_t                 rx_count;     // Operands received so far

    function automatic count_t sat_inc(input count_t c);
        return (c == '1) ? c : c + 1'b1;
    endfunction

    // Two-flop synchronisers plus edge history
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            sclk_sync <= '0;
            cs_sync   <= '1;      // Deselected
            mosi_sync <= '0;
            sclk_prev <= 1'b0;
            cs_prev   <= 1'b1;
        end else begin
            sclk_sync <= {sclk_sync[SYNC_STAGES-2:0], spi_sclk};
            cs_sync   <= {cs_sync[SYNC_STAGES-2:0], spi_cs_n};
            mosi_sync <= {mosi_sync[SYNC_STAGES-2:0], spi_mosi};
            sclk_prev <= sclk_sync[SYNC_STAGES-1];
            cs_prev   <= cs_sync[SYNC_STAGES-1];
        end
    end

    assign sclk_rise = sclk_sync[SYNC_STAGES-1] & ~sclk_prev;
    assign sclk_fall = ~sclk_sync[SYNC_STAGES-1] & sclk_prev;
    assign cs_low    = ~cs_sync[SYNC_STAGES-1];
    assign cs_fall   = cs_prev & cs_low;
    assign byte_done = sclk_rise && (bit_count == BIT_CNT_W'(BYTE_W - 1));
    assign rx_byte   = {shift_in[BYTE_W-2:0], mosi_sync[SYNC_STAGES-1]};

    // Receive side and command bus
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            bit_count         <= '0;
            shift_in          <= '0;
            rx_count          <= '0;
            cmd.opcode        <= '0;
            cmd.operand_count <= '0;
            cmd.operand_valid <= 1'b0;
            cmd.read_strobe   <= 1'b0;
            cmd.read_count    <= '0;
            cmd.frame_active  <= 1'b0;
        end else begin
            cmd.read_strobe <= 1'b0;                  // Single-cycle pulse
            if (cmd.operand_valid && cmd.operand_ready) begin
                cmd.operand_valid <= 1'b0;
            end
            if (!cs_low) begin
                // Deselect aborts whatever was in flight
                bit_count         <= '0;
                rx_count          <= '0;
                cmd.operand_valid <= 1'b0;
                cmd.read_count    <= '0;
                cmd.frame_active  <= 1'b0;
            end else if (sclk_rise) begin
                shift_in  <= rx_byte;
                bit_count <= bit_count + 1'b1;        // Wraps after eight bits
                if (byte_done && !cmd.frame_active) begin
                    cmd.opcode       <= rx_byte;      // First byte of the frame
                    cmd.frame_active <= 1'b1;
                    cmd.read_strobe  <= 1'b1;
                    cmd.read_count   <= '0;
                end else if (byte_done) begin
                    cmd.operand       <= rx_byte;
                    cmd.operand_valid <= 1'b1;
                    cmd.operand_count <= rx_count;
                    rx_count          <= sat_inc(rx_count);
                    cmd.read_strobe   <= 1'b1;
                    cmd.read_count    <= sat_inc(cmd.read_count);
                end
            end
        end
    end

    // Transmit side, MISO changes on SCLK fall
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            shift_out <= '0;
        end else if (!cs_low) begin
            shift_out <= '0;                          // Idle low between frames
        end else if (cs_fall) begin
            shift_out <= response;                    // Byte 0 slot
        end else if (sclk_fall) begin
            if (bit_count == '0) begin
                shift_out <= response;                // Eighth fall, next byte
            end else begin
                shift_out <= {shift_out[BYTE_W-2:0], 1'b0};
            end
        end
    end

    assign spi_miso = shift_out[BYTE_W-1];

endmodule

// File: rtl/spi_pkg.sv
//##########################################################################
// SPI command set and framing constants for the register-access link
//##########################################################################

package spi_pkg;

    localparam int BYTE_W      = 8;               // MSB first on the wire
    localparam int COUNT_W     = 8;               // Operand and response index
    localparam int BIT_CNT_W   = $clog2(BYTE_W);
    localparam int SYNC_STAGES = 2;               // Pin synchroniser depth

    typedef logic [BYTE_W-1:0]  byte_t;
    typedef logic [COUNT_W-1:0] count_t;          // Saturates at 255

    // Opcodes
    localparam byte_t OP_CHIP_ID   = 8'hDB;
    localparam byte_t OP_PLL_CTRL  = 8'h40;
    localparam byte_t OP_PAL_WRITE = 8'h11;       // Index, Y, CbCr
    localparam byte_t OP_PAL_INDEX = 8'h12;       // Read pointer
    localparam byte_t OP_PAL_READ  = 8'h13;       // Y then CbCr

    localparam byte_t CHIP_ID_VALUE = 8'h81;

    // PLL control and status byte layout
    localparam int PLL_PWR_BIT  = 0;
    localparam int PLL_SEL_BIT  = 1;
    localparam int PLL_LOCK_BIT = 2;              // Read only

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the frame controller testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_frame_ctrl -Mdir obj_dir -f compile.f
./obj_dir/Vtb_frame_ctrl +verilator+error+limit+100 | tee sim.log

if grep -q '\*\*\* TEST PASSED \*\*\*' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: verif/frame_ctrl_chk.sv
//##########################################################################
// Bound checks on the SPI command bus handshake and read strobes
//##########################################################################
`timescale 1ns/1ps

module frame_ctrl_chk (
    input logic           clock,
    input logic           rst_n,
    input spi_pkg::byte_t operand,
    input logic           operand_valid,
    input logic           operand_ready,
    input logic           read_strobe,
    input logic           frame_active
);
    int unsigned fail_count = 0;      // Failure tally

    // Stalled operand holds its value
    assert property (@(posedge clock) disable iff (!rst_n)
        (operand_valid && !operand_ready) |=> $stable(operand))
    else begin
        $error("operand changed while valid and not ready");
        fail_count++;
    end

    assert property (@(posedge clock) disable iff (!rst_n)
        read_strobe |-> frame_active)     // No strobe outside a frame
    else begin
        $error("read_strobe high without an active frame");
        fail_count++;
    end

    // Stall window is one cycle at most
    assert property (@(posedge clock) disable iff (!rst_n)
        !operand_ready |=> operand_ready)
    else begin
        $error("operand_ready low for two cycles in a row");
        fail_count++;
    end

endmodule

// File: verif/frame_ctrl_stimulus.txt
// Count word, then one transaction per line of 15 hex bytes:
// nbytes opcode d0 d1 d2 d3 ncheck r0 r1 r2 r3 pll_locked pwr_pin sel_pin err_pin
// r0..r3 are the response bytes shifted out during the bytes after the opcode
19
01 db 00 00 00 00 01 81 00 00 00 00 01 00 00  // Chip ID read
01 40 01 00 00 00 01 05 00 00 00 01 01 00 00  // Status before write, locked
01 40 03 00 00 00 01 05 00 00 00 01 01 01 00  // Select taken while locked
01 40 01 00 00 00 01 03 00 00 00 00 01 01 00  // Unlocked and powered, select held
01 40 00 00 00 00 01 03 00 00 00 00 00 01 00  // Power down, select still held
01 40 00 00 00 00 01 02 00 00 00 00 00 00 00  // Powered down, select free
01 40 03 00 00 00 01 00 00 00 00 00 01 01 00  // Power up and select together
01 40 01 00 00 00 01 07 00 00 00 01 01 00 00  // Lock bit in status
03 11 03 fa ed 00 00 00 00 00 00 01 01 00 00  // Entry 3, high bits masked
03 11 07 35 c6 00 00 00 00 00 00 01 01 00 00  // Entry 7
03 11 1c 0f 3f 00 00 00 00 00 00 01 01 00 00  // Index 0x1c wraps to 12
01 12 03 00 00 00 00 00 00 00 00 01 01 00 00
02 13 00 00 00 00 02 0a 2d 00 00 01 01 00 00  // Y then CbCr
01 12 0c 00 00 00 00 00 00 00 00 01 01 00 00
04 13 00 00 00 00 04 0f 3f 3f 3f 01 01 00 00  // CbCr repeats
01 12 17 00 00 00 00 00 00 00 00 01 01 00 00  // Pointer wraps to 7
02 13 00 00 00 00 02 05 06 00 00 01 01 00 00
02 11 07 09 00 00 00 00 00 00 00 01 01 00 00  // Cut short, no commit
02 13 00 00 00 00 02 05 06 00 00 01 01 00 00  // Entry 7 unchanged
01 12 00 00 00 00 00 00 00 00 00 01 01 00 00
02 13 00 00 00 00 02 00 00 00 00 01 01 00 00  // Never written, reads zero
01 5a 00 00 00 00 01 00 00 00 00 01 01 00 01  // Unknown opcode
01 db 00 00 00 00 01 81 00 00 00 01 01 00 01  // Error flag stays set
01 12 03 00 00 00 00 00 00 00 00 01 01 00 01
02 13 00 00 00 00 02 0a 2d 00 00 01 01 00 01

// File: verif/tb_frame_ctrl.sv
//##########################################################################
// Testbench for the register-access subsystem, SPI host driven from a file
//##########################################################################
`timescale 1ns/1ps

module tb_frame_ctrl;
    import spi_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int SCLK_HALF    = 8;      // System clocks per SCLK half period
    localparam int RESET_CYCLES = 4;
    localparam int PIN_DELAY    = 4;      // Clocks from CS rise to pin check
    localparam int MAX_TX       = 64;
    localparam int REC_W        = 15;     // Bytes per record
    localparam int BYTE_NS      = 2 * BYTE_W * SCLK_HALF * CLK_PERIOD;
    localparam int F_NBYTES     = 0;      // Record field offsets
    localparam int F_OPCODE     = 1;
    localparam int F_DATA       = 2;
    localparam int F_NCHECK     = 6;
    localparam int F_EXP        = 7;
    localparam int F_LOCK       = 11;
    localparam int F_PWR        = 12;
    localparam int F_SEL        = 13;
    localparam int F_ERR        = 14;

    logic   clock;
    logic   rst_n;
    logic   spi_sclk;
    logic   spi_cs_n;
    logic   spi_mosi;
    logic   pll_locked;
    logic   spi_miso;
    logic   pll_power_up;
    logic   buffer_read_select;
    logic   decode_error;
    byte_t  stim [0:MAX_TX*REC_W];        // Count word then records
    int     n_tx;
    int     read_errors;
    int     pin_errors;
    int     assert_errors;
    int     other_errors;
    longint watchdog_ns = 0;

    frame_ctrl_top u_frame_ctrl_top (
        .clock              (clock),
        .rst_n              (rst_n),
        .spi_sclk           (spi_sclk),
        .spi_cs_n           (spi_cs_n),
        .spi_mosi           (spi_mosi),
        .pll_locked         (pll_locked),
        .spi_miso           (spi_miso),
        .pll_power_up       (pll_power_up),
        .buffer_read_select (buffer_read_select),
        .decode_error       (decode_error)
    );

    bind spi_peripheral frame_ctrl_chk u_frame_ctrl_chk (
        .clock         (clock),
        .rst_n         (rst_n),
        .operand       (cmd.operand),
        .operand_valid (cmd.operand_valid),
        .operand_ready (cmd.operand_ready),
        .read_strobe   (cmd.read_strobe),
        .frame_active  (cmd.frame_active)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // Mode 0, MSB first; MISO taken just before SCLK rises
    task automatic shift_byte(input byte_t tx, output byte_t rx);
        for (int i = BYTE_W - 1; i >= 0; i--) begin
            spi_mosi = tx[i];
            repeat (SCLK_HALF) @(negedge clock);
            rx[i]    = spi_miso;
            spi_sclk = 1'b1;
            repeat (SCLK_HALF) @(negedge clock);
            spi_sclk = 1'b0;
        end
    endtask

    task automatic run_transaction(input int t);
        int    base;
        int    nbytes;
        int    ncheck;
        string name;
        byte_t expected;
        byte_t miso_bytes [5];
        base       = 1 + t * REC_W;
        nbytes     = int'(stim[base + F_NBYTES]);
        ncheck     = int'(stim[base + F_NCHECK]);
        name       = $sformatf("tx%0d op %h", t, stim[base + F_OPCODE]);
        pll_locked = stim[base + F_LOCK][0];
        spi_cs_n   = 1'b0;
        repeat (SCLK_HALF) @(negedge clock);
        shift_byte(stim[base + F_OPCODE], miso_bytes[0]);    // Stale byte, unchecked
        for (int b = 0; b < nbytes; b++) begin
            shift_byte(stim[base + F_DATA + b], miso_bytes[b + 1]);
        end
        repeat (SCLK_HALF) @(negedge clock);
        spi_cs_n = 1'b1;
        // Response k rides in the slot after operand byte k-1
        for (int k = 0; k < ncheck; k++) begin
            expected = stim[base + F_EXP + k];
            if (miso_bytes[k + 1] !== expected) begin
                $display("error %s read byte %0d: expected %h, actual %h",
                         name, k, expected, miso_bytes[k + 1]);
                read_errors++;
            end
        end
        repeat (PIN_DELAY) @(negedge clock);
        if (pll_power_up !== stim[base + F_PWR][0]) begin
            $display("error %s pll_power_up: expected %b, actual %b",
                     name, stim[base + F_PWR][0], pll_power_up);
            pin_errors++;
        end
        if (buffer_read_select !== stim[base + F_SEL][0]) begin
            $display("error %s buffer_read_select: expected %b, actual %b",
                     name, stim[base + F_SEL][0], buffer_read_select);
            pin_errors++;
        end
        if (decode_error !== stim[base + F_ERR][0]) begin
            $display("error %s decode_error: expected %b, actual %b",
                     name, stim[base + F_ERR][0], decode_error);
            pin_errors++;
        end
    endtask

    initial begin
        int unsigned gap;
        rst_n         = 1'b0;
        spi_sclk      = 1'b0;
        spi_cs_n      = 1'b1;
        spi_mosi      = 1'b0;
        pll_locked    = 1'b0;
        read_errors   = 0;
        pin_errors    = 0;
        other_errors  = 0;
        n_tx          = 0;
        void'($urandom(32'h4fd401a4));
        $readmemh("verif/frame_ctrl_stimulus.txt", stim);
        if ($isunknown(stim[0]) || stim[0] == 8'd0 || int'(stim[0]) > MAX_TX) begin
            $display("stimulus file is missing or holds no usable transaction count");
            other_errors++;
        end else begin
            n_tx = int'(stim[0]);
        end
        watchdog_ns = longint'(n_tx) * 40 * BYTE_NS + 100 * CLK_PERIOD;   // 40 bytes each
        repeat (RESET_CYCLES) @(negedge clock);
        rst_n = 1'b1;
        for (int t = 0; t < n_tx; t++) begin
            gap = $urandom_range(19, 4);      // Idle clocks between frames
            repeat (gap) @(negedge clock);
            run_transaction(t);
        end
        repeat (PIN_DELAY) @(negedge clock);
        assert_errors = int'(u_frame_ctrl_top.u_spi_peripheral.u_frame_ctrl_chk.fail_count);
        $display("errors: read %0d, pins %0d, assertions %0d, other %0d",
                 read_errors, pin_errors, assert_errors, other_errors);
        if (read_errors + pin_errors + assert_errors + other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog, armed once the transaction count is known
    initial begin
        wait (watchdog_ns != 0);
        #(watchdog_ns);
        $display("timeout: transactions did not finish within %0d ns", watchdog_ns);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
